//--- nkmd_cpu_params.svh
`ifndef NKMD_CPU_PARAMS_SVH
`define NKMD_CPU_PARAMS_SVH
`default_nettype none

`define NKMD_WORD_W   32
`define NKMD_REGSEL_W 4
`define NKMD_ALUSEL_W 3
`define NKMD_MWSEL_W  2

// Instruction fields
`define NKMD_F_MWSEL_HI 30
`define NKMD_F_MWSEL_LO 29
`define NKMD_F_RREAD    28
`define NKMD_F_RD_HI    27
`define NKMD_F_RD_LO    24
`define NKMD_F_ALU_HI   23
`define NKMD_F_ALU_LO   21
`define NKMD_F_RS_HI    20
`define NKMD_F_RS_LO    17
`define NKMD_F_IMMEN    16
`define NKMD_F_SIGN     15
`define NKMD_F_IMM_HI   14
`define NKMD_F_IMM_LO   0
`define NKMD_F_RT_HI    11
`define NKMD_F_RT_LO    8

// Register numbers
`define NKMD_REG_A  1
`define NKMD_REG_J  10
`define NKMD_REG_SL 12
`define NKMD_REG_SH 13

`default_nettype wire
`endif

//--- nkmd_cpu_pkg.sv
`include "nkmd_cpu_params.svh"
`default_nettype none

package nkmd_cpu_pkg;

    typedef logic [`NKMD_WORD_W-1:0]   word_t;
    typedef logic [`NKMD_REGSEL_W-1:0] regsel_t;

    // Codes 5 to 7 give zero
    typedef enum logic [`NKMD_ALUSEL_W-1:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_OR    = 3'd2,
        ALU_AND   = 3'd3,
        ALU_XOR   = 3'd4,
        ALU_RESV  = 3'd5,
        ALU_CLAMP = 3'd6,
        ALU_MUL   = 3'd7
    } alusel_t;

    // Result destination, T and C discard
    typedef enum logic [`NKMD_MWSEL_W-1:0] {
        MW_REG = 2'd0,
        MW_R   = 2'd1,
        MW_T   = 2'd2,
        MW_C   = 2'd3
    } mwsel_t;

endpackage

`default_nettype wire

//--- nkmd_cpu_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module nkmd_cpu_fetch import nkmd_cpu_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire word_t p_data_i,
    output word_t      p_addr_o,
    output word_t      inst_o
);

    word_t pc_q;

    // No jumps, the counter only steps forward
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_q + 1'b1;
        end
    end

    assign p_addr_o = pc_q;
    assign inst_o   = p_data_i;

endmodule

`default_nettype wire

//--- nkmd_cpu_decode.sv
`timescale 1ns/1ps
`include "nkmd_cpu_params.svh"
`default_nettype none

module nkmd_cpu_decode import nkmd_cpu_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire word_t inst_i,
    output regsel_t    rssel_o,
    output regsel_t    rtsel_o,
    output regsel_t    rdsel_o,
    output alusel_t    alusel_o,
    output word_t      imm_o,
    output logic       imm_en_o,
    output logic       r_read_en_o,
    output mwsel_t     mwsel_o
);

    logic rst_d_q;
    word_t imm_ext;

    always_ff @(posedge clk) begin
        rst_d_q <= rst;
    end

    assign imm_ext = {{(`NKMD_WORD_W - 15){inst_i[`NKMD_F_SIGN]}},
                      inst_i[`NKMD_F_IMM_HI:`NKMD_F_IMM_LO]};

    // Cleared state is add into register 0, a no-op
    always_ff @(posedge clk) begin
        if (rst || rst_d_q) begin
            rssel_o     <= '0;
            rtsel_o     <= '0;
            rdsel_o     <= '0;
            alusel_o    <= ALU_ADD;
            imm_o       <= '0;
            imm_en_o    <= 1'b0;
            r_read_en_o <= 1'b0;
            mwsel_o     <= MW_REG;
        end else begin
            rssel_o     <= inst_i[`NKMD_F_RS_HI:`NKMD_F_RS_LO];
            rtsel_o     <= inst_i[`NKMD_F_RT_HI:`NKMD_F_RT_LO];
            rdsel_o     <= inst_i[`NKMD_F_RD_HI:`NKMD_F_RD_LO];
            alusel_o    <= alusel_t'(inst_i[`NKMD_F_ALU_HI:`NKMD_F_ALU_LO]);
            imm_o       <= imm_ext;
            imm_en_o    <= inst_i[`NKMD_F_IMMEN];
            r_read_en_o <= inst_i[`NKMD_F_RREAD];
            mwsel_o     <= mwsel_t'(inst_i[`NKMD_F_MWSEL_HI:`NKMD_F_MWSEL_LO]);
        end
    end

endmodule

`default_nettype wire

//--- nkmd_cpu_regfile.sv
`timescale 1ns/1ps
`include "nkmd_cpu_params.svh"
`default_nettype none

module nkmd_cpu_regfile import nkmd_cpu_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire regsel_t rssel_i,
    input  wire regsel_t rtsel_i,
    input  wire regsel_t rdsel_i,
    input  wire regsel_t wb_sel_i,
    input  wire word_t   wb_val_i,
    output word_t        rsval_o,
    output word_t        rtval_o,
    output word_t        rdval_o
);

    // Slot 11 is never written
    word_t regs_q [`NKMD_REG_A:`NKMD_REG_SH];

    // a to j, sl and sh
    function automatic logic implemented(regsel_t sel);
        return (sel >= `NKMD_REG_A && sel <= `NKMD_REG_J) ||
               sel == `NKMD_REG_SL || sel == `NKMD_REG_SH;
    endfunction

    function automatic word_t read_reg(regsel_t sel);
        return implemented(sel) ? regs_q[sel] : '0;
    endfunction

    always_comb begin
        rsval_o = read_reg(rssel_i);
        rtval_o = read_reg(rtsel_i);
        rdval_o = read_reg(rdsel_i);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = `NKMD_REG_A; i <= `NKMD_REG_SH; i++) begin
                regs_q[i] <= '0;
            end
        end else if (implemented(wb_sel_i)) begin
            regs_q[wb_sel_i] <= wb_val_i;
        end
    end

endmodule

`default_nettype wire

//--- nkmd_cpu_mem.sv
`timescale 1ns/1ps
`default_nettype none

module nkmd_cpu_mem import nkmd_cpu_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire word_t   imm_i,
    input  wire          imm_en_i,
    input  wire          r_read_en_i,
    input  wire word_t   rsval_i,
    input  wire word_t   rtval_i,
    input  wire word_t   rdval_i,
    input  wire alusel_t alusel_i,
    input  wire regsel_t rdsel_i,
    input  wire mwsel_t  mwsel_i,
    input  wire word_t   r_data_i,
    output word_t        r_read_addr_o,
    output word_t        sval_o,
    output word_t        tval_o,
    output word_t        dval_o,
    output alusel_t      alusel_o,
    output regsel_t      rdsel_o,
    output mwsel_t       mwsel_o
);

    word_t addr_q;
    logic  r_read_en_q;

    // Effective address, also the immediate operand path
    assign r_read_addr_o = imm_en_i ? imm_i : rtval_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            r_read_en_q <= 1'b0;
            alusel_o    <= ALU_ADD;
            rdsel_o     <= '0;
            mwsel_o     <= MW_REG;
        end else begin
            r_read_en_q <= r_read_en_i;
            alusel_o    <= alusel_i;
            rdsel_o     <= rdsel_i;
            mwsel_o     <= mwsel_i;
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= r_read_addr_o;
        sval_o <= rsval_i;
        dval_o <= rdval_i;
    end

    // R data arrives one cycle after the address
    assign tval_o = r_read_en_q ? r_data_i : addr_q;

endmodule

`default_nettype wire

//--- nkmd_cpu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module nkmd_cpu_execute import nkmd_cpu_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire word_t   sval_i,
    input  wire word_t   tval_i,
    input  wire word_t   dval_i,
    input  wire alusel_t alusel_i,
    input  wire regsel_t rdsel_i,
    input  wire mwsel_t  mwsel_i,
    input  wire word_t   r_read_addr_i,
    output regsel_t      rf_sel_o,
    output word_t        rf_val_o,
    output word_t        r_addr_o,
    output word_t        r_data_o,
    output logic         r_we_o
);

    word_t   alu_d;
    word_t   alu_q;
    word_t   dval_q;
    regsel_t rdsel_q;
    mwsel_t  mwsel_q;

    always_comb begin
        case (alusel_i)
            ALU_ADD: alu_d = sval_i + tval_i;
            ALU_SUB: alu_d = sval_i - tval_i;
            ALU_OR:  alu_d = sval_i | tval_i;
            ALU_AND: alu_d = sval_i & tval_i;
            ALU_XOR: alu_d = sval_i ^ tval_i;
            // Reserved, clamp and mul
            default: alu_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdsel_q <= '0;
            mwsel_q <= MW_REG;
        end else begin
            rdsel_q <= rdsel_i;
            mwsel_q <= mwsel_i;
        end
    end

    always_ff @(posedge clk) begin
        alu_q  <= alu_d;
        dval_q <= dval_i;
    end

    // Writeback steering
    assign rf_sel_o = (mwsel_q == MW_REG) ? rdsel_q : '0;
    assign rf_val_o = alu_q;
    assign r_we_o   = (mwsel_q == MW_R);
    assign r_data_o = alu_q;
    // A store takes the address port from the pending read
    assign r_addr_o = r_we_o ? dval_q : r_read_addr_i;

endmodule

`default_nettype wire

//--- nkmd_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module nkmd_cpu import nkmd_cpu_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire word_t p_data_i,
    input  wire word_t r_data_i,
    output word_t      p_addr_o,
    output word_t      r_addr_o,
    output word_t      r_data_o,
    output logic       r_we_o
);

    // Fetch to decode
    word_t   inst;

    // Decode outputs
    regsel_t dcd_rssel;
    regsel_t dcd_rtsel;
    regsel_t dcd_rdsel;
    alusel_t dcd_alusel;
    word_t   dcd_imm;
    logic    dcd_imm_en;
    logic    dcd_r_read_en;
    mwsel_t  dcd_mwsel;

    // Register file ports
    word_t   rf_rsval;
    word_t   rf_rtval;
    word_t   rf_rdval;
    regsel_t wb_sel;
    word_t   wb_val;

    // Memory stage to execute
    word_t   mem_r_read_addr;
    word_t   mem_sval;
    word_t   mem_tval;
    word_t   mem_dval;
    alusel_t mem_alusel;
    regsel_t mem_rdsel;
    mwsel_t  mem_mwsel;

    nkmd_cpu_fetch fetch_inst (
        .clk      (clk),
        .rst      (rst),
        .p_data_i (p_data_i),
        .p_addr_o (p_addr_o),
        .inst_o   (inst)
    );

    nkmd_cpu_decode decode_inst (
        .clk         (clk),
        .rst         (rst),
        .inst_i      (inst),
        .rssel_o     (dcd_rssel),
        .rtsel_o     (dcd_rtsel),
        .rdsel_o     (dcd_rdsel),
        .alusel_o    (dcd_alusel),
        .imm_o       (dcd_imm),
        .imm_en_o    (dcd_imm_en),
        .r_read_en_o (dcd_r_read_en),
        .mwsel_o     (dcd_mwsel)
    );

    nkmd_cpu_regfile regfile_inst (
        .clk      (clk),
        .rst      (rst),
        .rssel_i  (dcd_rssel),
        .rtsel_i  (dcd_rtsel),
        .rdsel_i  (dcd_rdsel),
        .wb_sel_i (wb_sel),
        .wb_val_i (wb_val),
        .rsval_o  (rf_rsval),
        .rtval_o  (rf_rtval),
        .rdval_o  (rf_rdval)
    );

    nkmd_cpu_mem mem_inst (
        .clk           (clk),
        .rst           (rst),
        .imm_i         (dcd_imm),
        .imm_en_i      (dcd_imm_en),
        .r_read_en_i   (dcd_r_read_en),
        .rsval_i       (rf_rsval),
        .rtval_i       (rf_rtval),
        .rdval_i       (rf_rdval),
        .alusel_i      (dcd_alusel),
        .rdsel_i       (dcd_rdsel),
        .mwsel_i       (dcd_mwsel),
        .r_data_i      (r_data_i),
        .r_read_addr_o (mem_r_read_addr),
        .sval_o        (mem_sval),
        .tval_o        (mem_tval),
        .dval_o        (mem_dval),
        .alusel_o      (mem_alusel),
        .rdsel_o       (mem_rdsel),
        .mwsel_o       (mem_mwsel)
    );

    nkmd_cpu_execute execute_inst (
        .clk           (clk),
        .rst           (rst),
        .sval_i        (mem_sval),
        .tval_i        (mem_tval),
        .dval_i        (mem_dval),
        .alusel_i      (mem_alusel),
        .rdsel_i       (mem_rdsel),
        .mwsel_i       (mem_mwsel),
        .r_read_addr_i (mem_r_read_addr),
        .rf_sel_o      (wb_sel),
        .rf_val_o      (wb_val),
        .r_addr_o      (r_addr_o),
        .r_data_o      (r_data_o),
        .r_we_o        (r_we_o)
    );

endmodule

`default_nettype wire

//--- nkmd_cpu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module nkmd_cpu_asserts import nkmd_cpu_pkg::*; (
    input wire        clk,
    input wire        rst,
    input wire word_t p_addr_i,
    input wire        r_we_i
);

    // Straight-line fetch, no jumps
    property pc_steps;
        @(posedge clk) disable iff (rst)
            !$past(rst) |-> p_addr_i == $past(p_addr_i) + 32'd1;
    endproperty

    property no_store_in_reset;
        @(posedge clk) rst |=> !r_we_i;
    endproperty

    property we_known;
        @(posedge clk) disable iff (rst) !$isunknown(r_we_i);
    endproperty

    assert property (pc_steps) else $error("p_addr_o did not step by one");
    assert property (no_store_in_reset) else $error("r_we_o high during reset");
    assert property (we_known) else $error("r_we_o is unknown");

endmodule

bind nkmd_cpu nkmd_cpu_asserts nkmd_cpu_asserts_inst (
    .clk      (clk),
    .rst      (rst),
    .p_addr_i (p_addr_o),
    .r_we_i   (r_we_o)
);

`default_nettype wire

//--- tb_nkmd_cpu.sv
`timescale 1ns/1ps
`include "nkmd_cpu_params.svh"
`default_nettype none

module tb_nkmd_cpu import nkmd_cpu_pkg::*; ();

    localparam int NUM_TESTS = 5;
    localparam int PROG_LEN  = 64;
    localparam int R_DEPTH   = 256;

    logic   clk = 1'b0;
    logic   rst = 1'b1;
    word_t  p_data_i;
    word_t  r_data_i = '0;
    word_t  p_addr_o;
    word_t  r_addr_o;
    word_t  r_data_o;
    logic   r_we_o;

    word_t  prog [PROG_LEN];
    word_t  r_mem [R_DEPTH];
    word_t  exp_addr [$];
    word_t  exp_data [$];
    word_t  got_addr [$];
    word_t  got_data [$];
    int     prog_len;
    int     errors = 0;
    int     start_errors;
    int     tests_run = 0;
    int     tests_failed = 0;
    integer seed = 32'h320e6b88;
    string  cur_test;

    always #20 clk = ~clk;

    nkmd_cpu nkmd_cpu_inst (
        .clk      (clk),
        .rst      (rst),
        .p_data_i (p_data_i),
        .r_data_i (r_data_i),
        .p_addr_o (p_addr_o),
        .r_addr_o (r_addr_o),
        .r_data_o (r_data_o),
        .r_we_o   (r_we_o)
    );

    function automatic word_t fill_word(word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h3c5a_0f96;
    endfunction

    function automatic word_t sext(logic [15:0] imm16);
        return {{16{imm16[15]}}, imm16};
    endfunction

    function automatic word_t alu_ref(alusel_t op, word_t s, word_t t);
        case (op)
            ALU_ADD: return s + t;
            ALU_SUB: return s - t;
            ALU_OR:  return s | t;
            ALU_AND: return s & t;
            ALU_XOR: return s ^ t;
            default: return '0;
        endcase
    endfunction

    function automatic word_t encode(mwsel_t mw, logic rread, regsel_t rd, alusel_t alu,
                                     regsel_t rs, logic imm_en, logic [15:0] imm16,
                                     regsel_t rt);
        word_t inst;
        inst = '0;
        inst[`NKMD_F_MWSEL_HI:`NKMD_F_MWSEL_LO] = mw;
        inst[`NKMD_F_RREAD] = rread;
        inst[`NKMD_F_RD_HI:`NKMD_F_RD_LO] = rd;
        inst[`NKMD_F_ALU_HI:`NKMD_F_ALU_LO] = alu;
        inst[`NKMD_F_RS_HI:`NKMD_F_RS_LO] = rs;
        inst[`NKMD_F_IMMEN] = imm_en;
        if (imm_en) begin
            inst[`NKMD_F_SIGN:`NKMD_F_IMM_LO] = imm16;
        end else begin
            inst[`NKMD_F_RT_HI:`NKMD_F_RT_LO] = rt;
        end
        return inst;
    endfunction

    // Combinational program bus, unloaded words are no-ops
    always_comb begin
        if (p_addr_o < PROG_LEN) begin
            p_data_i = prog[p_addr_o];
        end else begin
            p_data_i = '0;
        end
    end

    // R memory, read data one cycle after the address
    always @(posedge clk) begin
        if (r_we_o === 1'b1 && r_addr_o < R_DEPTH) begin
            r_mem[r_addr_o] <= r_data_o;
        end
        if (rst) begin
            r_data_i <= '0;
        end else if (r_addr_o < R_DEPTH) begin
            r_data_i <= r_mem[r_addr_o];
        end else begin
            r_data_i <= fill_word(r_addr_o);
        end
    end

    always @(negedge clk) begin
        if (!rst && r_we_o === 1'b1) begin
            got_addr.push_back(r_addr_o);
            got_data.push_back(r_data_o);
        end
    end

    task automatic check_word(string what, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("error %s %s: expected %h, actual %h", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(string what, logic expected, logic actual);
        if (actual !== expected) begin
            $display("error %s %s: expected %b, actual %b", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic emit(word_t inst);
        prog[prog_len] = inst;
        prog_len++;
    endtask

    task automatic load_imm(regsel_t rd, logic [15:0] imm16);
        emit(encode(MW_REG, 1'b0, rd, ALU_ADD, '0, 1'b1, imm16, '0));
    endtask

    // Three no-ops between a writer and its reader
    task automatic pad();
        repeat (3) emit('0);
    endtask

    task automatic store(alusel_t alu, regsel_t addr_reg, regsel_t rs, regsel_t rt,
                         word_t addr, word_t data);
        emit(encode(MW_R, 1'b0, addr_reg, alu, rs, 1'b0, '0, rt));
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic begin_test(string name);
        cur_test = name;
        start_errors = errors;
        @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i] = '0;
        end
        for (int i = 0; i < R_DEPTH; i++) begin
            r_mem[i] <= fill_word(word_t'(i));
        end
        prog_len = 0;
        exp_addr.delete();
        exp_data.delete();
        got_addr.delete();
        got_data.delete();
        // Address 0 falls into the decode flush after reset
        emit('0);
    endtask

    task automatic release_reset();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic finish_test();
        int cycles;
        cycles = 0;
        while (p_addr_o < prog_len + 4 && cycles < 2 * PROG_LEN) begin
            @(negedge clk);
            cycles++;
        end
        if (p_addr_o < prog_len + 4) begin
            $display("%s: program counter never reached the end of the program", cur_test);
            errors++;
        end
        check_word("store count", word_t'(exp_addr.size()), word_t'(got_addr.size()));
        foreach (exp_addr[i]) begin
            if (i < got_addr.size()) begin
                check_word("store address", exp_addr[i], got_addr[i]);
                check_word("store data", exp_data[i], got_data[i]);
            end
        end
        tests_run++;
        if (errors == start_errors) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - start_errors);
        end
    endtask

    task automatic test_fetch();
        begin_test("fetch");
        repeat (20) emit('0);
        release_reset();
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            check_word("p_addr_o", word_t'(i), p_addr_o);
            check_bit("r_we_o", 1'b0, r_we_o);
        end
        finish_test();
    endtask

    task automatic test_imm_store();
        begin_test("imm_store");
        load_imm(1, 16'h1234);
        load_imm(2, 16'h8005);
        load_imm(3, 16'h0040);
        load_imm(4, 16'h0041);
        load_imm(5, 16'hc3a5);
        pad();
        store(ALU_ADD, 3, 1, 0, sext(16'h0040), sext(16'h1234));
        store(ALU_ADD, 4, 2, 0, sext(16'h0041), sext(16'h8005));
        store(ALU_ADD, 4, 5, 0, sext(16'h0041), sext(16'hc3a5));
        release_reset();
        finish_test();
    endtask

    task automatic test_alu();
        logic [15:0] xi;
        logic [15:0] yi;
        begin_test("alu");
        load_imm(`NKMD_REG_J, 16'h0050);
        for (int p = 0; p < 2; p++) begin
            xi = 16'($random(seed));
            yi = 16'($random(seed));
            load_imm(1, xi);
            load_imm(2, yi);
            pad();
            for (int op = 0; op < 8; op++) begin
                store(alusel_t'(op), `NKMD_REG_J, 1, 2, sext(16'h0050),
                      alu_ref(alusel_t'(op), sext(xi), sext(yi)));
            end
        end
        release_reset();
        finish_test();
    endtask

    task automatic test_r_load();
        word_t m0;
        word_t m1;
        begin_test("r_load");
        m0 = $random(seed);
        m1 = $random(seed);
        r_mem[32'h20] <= m0;
        r_mem[32'h21] <= m1;
        load_imm(3, 16'h0030);
        load_imm(5, 16'h0123);
        emit(encode(MW_REG, 1'b1, 1, ALU_ADD, 0, 1'b1, 16'h0020, 0));
        emit(encode(MW_REG, 1'b1, 2, ALU_ADD, 0, 1'b1, 16'h0021, 0));
        pad();
        store(ALU_ADD, 3, 1, 5, sext(16'h0030), m0 + sext(16'h0123));
        store(ALU_SUB, 3, 2, 5, sext(16'h0030), m1 - sext(16'h0123));
        store(ALU_ADD, 3, 2, 0, sext(16'h0030), m1);
        release_reset();
        finish_test();
    endtask

    task automatic test_regfile();
        begin_test("regfile");
        load_imm(1, 16'h0777);
        load_imm(0, 16'h0111);
        load_imm(11, 16'h0222);
        load_imm(14, 16'h0333);
        load_imm(15, 16'h0444);
        load_imm(`NKMD_REG_SL, 16'h0555);
        load_imm(`NKMD_REG_SH, 16'h8666);
        load_imm(3, 16'h0060);
        // Discarded results must leave a alone
        emit(encode(MW_T, 1'b0, 1, ALU_ADD, 0, 1'b1, 16'h0123, 0));
        emit(encode(MW_C, 1'b0, 1, ALU_ADD, 0, 1'b1, 16'h0456, 0));
        pad();
        store(ALU_ADD, 3, 0, 0, sext(16'h0060), '0);
        store(ALU_ADD, 3, 11, 0, sext(16'h0060), '0);
        store(ALU_ADD, 3, 14, 0, sext(16'h0060), '0);
        store(ALU_ADD, 3, 15, 0, sext(16'h0060), '0);
        store(ALU_ADD, 3, `NKMD_REG_SL, 0, sext(16'h0060), sext(16'h0555));
        store(ALU_ADD, 3, `NKMD_REG_SH, 0, sext(16'h0060), sext(16'h8666));
        store(ALU_ADD, 3, 1, 0, sext(16'h0060), sext(16'h0777));
        release_reset();
        finish_test();
    endtask

    initial begin
        test_fetch();
        test_imm_store();
        test_alu();
        test_r_load();
        test_regfile();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Each test stays well under 64 cycles
    initial begin
        #(NUM_TESTS * 64 * 40 * 2);
        $display("watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- nkmd_cpu.f
+incdir+.
nkmd_cpu_pkg.sv
nkmd_cpu_fetch.sv
nkmd_cpu_decode.sv
nkmd_cpu_regfile.sv
nkmd_cpu_mem.sv
nkmd_cpu_execute.sv
nkmd_cpu.sv
nkmd_cpu_asserts.sv
tb_nkmd_cpu.sv

//--- Bender.yml
package:
  name: nkmd_cpu

export_include_dirs:
  - .

sources:
  - nkmd_cpu_pkg.sv
  - nkmd_cpu_fetch.sv
  - nkmd_cpu_decode.sv
  - nkmd_cpu_regfile.sv
  - nkmd_cpu_mem.sv
  - nkmd_cpu_execute.sv
  - nkmd_cpu.sv
  - target: test
    files:
      - nkmd_cpu_asserts.sv
      - tb_nkmd_cpu.sv
